/* project.f */
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decoder.sv
hw/regfile.sv
hw/exe_stage.sv
hw/datapath.sv
bench/imem_wb.sv
bench/datapath_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module datapath_tb \
    -f project.f -o datapath_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/datapath_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* bench/datapath_tb.sv */
`timescale 1ns/1ps

module datapath_tb;
    import core_pkg::*;

    localparam int NUM_TESTS         = 6;
    localparam int MAX_LEN           = 16;
    localparam int SRST_CYCLES       = 3;
    // Idle window after the last expected retire
    localparam int QUIET_CYCLES      = 24;
    localparam int CYCLES_PER_RETIRE = 8;

    logic                  clk_i = 1'b0;
    logic                  rstn;
    logic                  soft_rstn;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic [XLEN-1:0]       wb_adr;
    logic                  wb_ack;
    logic [XLEN-1:0]       wb_dat;
    logic                  retire_valid;
    logic [XLEN-1:0]       retire_pc;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_data;

    // Program slots and expected retires per test row
    logic [31:0]           prog_tab [NUM_TESTS][MAX_LEN];
    int                    prog_len [NUM_TESTS];
    logic [XLEN-1:0]       exp_pc   [NUM_TESTS][MAX_LEN];
    logic [REG_ADDR_W-1:0] exp_rd   [NUM_TESTS][MAX_LEN];
    logic [XLEN-1:0]       exp_data [NUM_TESTS][MAX_LEN];
    int                    exp_len  [NUM_TESTS];
    string                 test_name[NUM_TESTS];
    // Row interrupted by the next row's soft reset
    bit                    cut_short[NUM_TESTS];
    bit                    tables_ready = 1'b0;
    int                    errors = 0;

    always #5 clk_i = ~clk_i;

    datapath dut_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn),
        .soft_rstn_i   (soft_rstn),
        .wb_ack_i      (wb_ack),
        .wb_dat_i      (wb_dat),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_adr_o      (wb_adr),
        .retire_valid_o(retire_valid),
        .retire_pc_o   (retire_pc),
        .retire_rd_o   (retire_rd),
        .retire_data_o (retire_data)
    );

    imem_wb imem_i (
        .clk_i (clk_i),
        .rstn_i(rstn),
        .cyc_i (wb_cyc),
        .stb_i (wb_stb),
        .adr_i (wb_adr),
        .ack_o (wb_ack),
        .dat_o (wb_dat)
    );

    // RV32I encoders
    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Next program slot; pc is the slot address, retiring slots add an expectation
    task automatic add_slot(input int t, input logic [31:0] instr, input bit retires,
                            input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] data);
        prog_tab[t][prog_len[t]] = instr;
        if (retires) begin
            exp_pc[t][exp_len[t]]   = XLEN'(4 * prog_len[t]);
            exp_rd[t][exp_len[t]]   = rd;
            exp_data[t][exp_len[t]] = data;
            exp_len[t]++;
        end
        prog_len[t]++;
    endtask

    task automatic build_tables();
        test_name[0] = "immediates";
        add_slot(0, enc_i(3'b000, 5'd1, 5'd0, 12'd100), 1, 5'd1, 32'd100);
        add_slot(0, enc_i(3'b111, 5'd2, 5'd1, 12'h0F0), 1, 5'd2, 32'h60);
        add_slot(0, enc_i(3'b110, 5'd3, 5'd2, 12'h00F), 1, 5'd3, 32'h6F);
        add_slot(0, enc_i(3'b100, 5'd4, 5'd3, 12'hFFF), 1, 5'd4, 32'hFFFF_FF90);
        add_slot(0, enc_i(3'b010, 5'd5, 5'd4, 12'h000), 1, 5'd5, 32'd1);
        add_slot(0, enc_i(3'b010, 5'd6, 5'd1, 12'hFFB), 1, 5'd6, 32'd0);
        add_slot(0, enc_lui(5'd7, 20'hABCDE), 1, 5'd7, 32'hABCD_E000);
        // Back-to-back on x1..x8
        test_name[1] = "register ops";
        add_slot(1, enc_i(3'b000, 5'd1, 5'd0, 12'hFF0), 1, 5'd1, 32'hFFFF_FFF0);
        add_slot(1, enc_i(3'b000, 5'd2, 5'd0, 12'd3), 1, 5'd2, 32'd3);
        add_slot(1, enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 1, 5'd3, 32'hFFFF_FFF3);
        add_slot(1, enc_r(7'h20, 3'b000, 5'd3, 5'd3, 5'd2), 1, 5'd3, 32'hFFFF_FFF0);
        add_slot(1, enc_r(7'h00, 3'b010, 5'd4, 5'd3, 5'd2), 1, 5'd4, 32'd1);
        add_slot(1, enc_r(7'h00, 3'b001, 5'd5, 5'd2, 5'd2), 1, 5'd5, 32'd24);
        add_slot(1, enc_r(7'h00, 3'b101, 5'd6, 5'd1, 5'd2), 1, 5'd6, 32'h1FFF_FFFE);
        add_slot(1, enc_r(7'h20, 3'b101, 5'd6, 5'd1, 5'd2), 1, 5'd6, 32'hFFFF_FFFE);
        add_slot(1, enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd5), 1, 5'd7, 32'hFFFF_FFE6);
        add_slot(1, enc_r(7'h00, 3'b110, 5'd7, 5'd7, 5'd4), 1, 5'd7, 32'hFFFF_FFE7);
        add_slot(1, enc_r(7'h00, 3'b111, 5'd8, 5'd7, 5'd2), 1, 5'd8, 32'd3);
        // Taken branches skip two slots each
        test_name[2] = "branches";
        add_slot(2, enc_i(3'b000, 5'd1, 5'd0, 12'd5), 1, 5'd1, 32'd5);
        add_slot(2, enc_i(3'b000, 5'd2, 5'd0, 12'd5), 1, 5'd2, 32'd5);
        add_slot(2, enc_b(3'b000, 5'd1, 5'd2, 13'd12), 1, 5'd0, 32'd0);
        add_slot(2, enc_i(3'b000, 5'd10, 5'd0, 12'd1), 0, 5'd0, 32'd0);
        add_slot(2, enc_i(3'b000, 5'd10, 5'd0, 12'd2), 0, 5'd0, 32'd0);
        add_slot(2, enc_b(3'b001, 5'd1, 5'd2, 13'd8), 1, 5'd0, 32'd0);
        add_slot(2, enc_i(3'b000, 5'd3, 5'd0, 12'hFFF), 1, 5'd3, 32'hFFFF_FFFF);
        add_slot(2, enc_b(3'b100, 5'd3, 5'd1, 13'd12), 1, 5'd0, 32'd0);
        add_slot(2, enc_i(3'b000, 5'd10, 5'd0, 12'd3), 0, 5'd0, 32'd0);
        add_slot(2, enc_i(3'b000, 5'd10, 5'd0, 12'd4), 0, 5'd0, 32'd0);
        add_slot(2, enc_b(3'b001, 5'd3, 5'd1, 13'd12), 1, 5'd0, 32'd0);
        add_slot(2, enc_i(3'b000, 5'd11, 5'd0, 12'd5), 0, 5'd0, 32'd0);
        add_slot(2, enc_i(3'b000, 5'd11, 5'd0, 12'd6), 0, 5'd0, 32'd0);
        add_slot(2, enc_b(3'b100, 5'd1, 5'd3, 13'd8), 1, 5'd0, 32'd0);
        add_slot(2, enc_r(7'h00, 3'b000, 5'd4, 5'd1, 5'd3), 1, 5'd4, 32'd4);
        test_name[3] = "jal";
        add_slot(3, enc_i(3'b000, 5'd1, 5'd0, 12'd7), 1, 5'd1, 32'd7);
        add_slot(3, enc_jal(5'd5, 21'd12), 1, 5'd5, 32'h8);
        add_slot(3, enc_i(3'b000, 5'd1, 5'd0, 12'd99), 0, 5'd0, 32'd0);
        add_slot(3, enc_i(3'b000, 5'd1, 5'd0, 12'd98), 0, 5'd0, 32'd0);
        add_slot(3, enc_r(7'h00, 3'b000, 5'd6, 5'd5, 5'd1), 1, 5'd6, 32'd15);
        add_slot(3, enc_jal(5'd0, 21'd8), 1, 5'd0, 32'h18);
        add_slot(3, enc_i(3'b000, 5'd6, 5'd0, 12'd1), 0, 5'd0, 32'd0);
        add_slot(3, enc_i(3'b000, 5'd7, 5'd5, 12'd4), 1, 5'd7, 32'd12);
        // Soft reset lands while slots 2 and 3 are in flight
        test_name[4] = "soft reset mid-program";
        cut_short[4] = 1'b1;
        add_slot(4, enc_i(3'b000, 5'd20, 5'd0, 12'd77), 1, 5'd20, 32'd77);
        add_slot(4, enc_i(3'b000, 5'd21, 5'd0, 12'd5), 1, 5'd21, 32'd5);
        add_slot(4, enc_i(3'b000, 5'd22, 5'd0, 12'd1), 0, 5'd0, 32'd0);
        add_slot(4, enc_i(3'b000, 5'd23, 5'd0, 12'd1), 0, 5'd0, 32'd0);
        test_name[5] = "registers kept over soft reset";
        add_slot(5, enc_r(7'h00, 3'b000, 5'd22, 5'd20, 5'd21), 1, 5'd22, 32'd82);
        add_slot(5, enc_r(7'h20, 3'b000, 5'd23, 5'd20, 5'd21), 1, 5'd23, 32'd72);
    endtask

    // Program at 0, rest unsupported opcode 0 tagged with the word index
    task automatic load_program(input int t);
        for (int k = 0; k < 256; k++) begin
            if (k < prog_len[t]) begin
                imem_i.mem[k] = prog_tab[t][k];
            end else begin
                imem_i.mem[k] = {k[24:0], 7'b0000000};
            end
        end
    endtask

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string what, input logic [REG_ADDR_W-1:0] got,
                             input logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s is x%0d, expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        errors++;
    endtask

    // Hold soft reset 3 cycles, swap the program while the pipeline is empty
    task automatic apply_soft_reset(input int t);
        @(posedge clk_i);
        soft_rstn <= 1'b0;
        @(posedge clk_i);
        @(negedge clk_i);
        load_program(t);
        repeat (SRST_CYCLES - 1) begin
            if (retire_valid) report_error("instruction retired while soft reset was held");
            if (wb_cyc || wb_stb) report_error("bus request while soft reset was held");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        soft_rstn <= 1'b1;
    endtask

    initial begin : watchdog
        int budget;
        int t;
        wait (tables_ready);
        budget = 200;
        for (t = 0; t < NUM_TESTS; t++) begin
            budget += exp_len[t] * CYCLES_PER_RETIRE + SRST_CYCLES + QUIET_CYCLES + 100;
        end
        repeat (budget) @(posedge clk_i);
        $display("ERROR: run did not finish within %0d cycles, the core stopped retiring", budget);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int passed;
        int failed;
        int errors_before;
        int got;
        int t;
        passed    = 0;
        failed    = 0;
        rstn      = 1'b0;
        soft_rstn = 1'b1;
        build_tables();
        load_program(0);
        tables_ready = 1'b1;
        repeat (SRST_CYCLES) @(posedge clk_i);
        rstn <= 1'b1;
        // Empty pipeline until the first fetch completes
        @(negedge clk_i);
        while (!wb_ack) begin
            if (retire_valid) report_error("instruction retired before the first fetch");
            @(negedge clk_i);
        end
        // First read after reset goes to the boot address
        check_word("first fetch address", wb_adr, RESET_PC);
        for (t = 0; t < NUM_TESTS; t++) begin
            errors_before = errors;
            apply_soft_reset(t);
            got = 0;
            while (got < exp_len[t]) begin
                @(negedge clk_i);
                if (retire_valid) begin
                    check_word("retire pc", retire_pc, exp_pc[t][got]);
                    check_reg("retire rd", retire_rd, exp_rd[t][got]);
                    check_word("retire data", retire_data, exp_data[t][got]);
                    got++;
                end
            end
            // Squashed slots and filler must stay silent
            if (!cut_short[t]) begin
                repeat (QUIET_CYCLES) begin
                    @(negedge clk_i);
                    if (retire_valid) report_error($sformatf("extra retire at pc %h", retire_pc));
                end
            end
            if (errors == errors_before) begin
                passed++;
                $display("test %0d (%s): ok", t, test_name[t]);
            end else begin
                failed++;
                $display("test %0d (%s): failed", t, test_name[t]);
            end
        end
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/imem_wb.sv */
`timescale 1ns/1ps

module imem_wb (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic [31:0] adr_i,
    output logic        ack_o,
    output logic [31:0] dat_o
);
    // 256 words, loaded by the testbench
    logic [31:0] mem [0:255];
    // Wait-state generator state
    int          seed = 10358;
    // Wait states left before the current read is acked
    logic [1:0]  wait_q;

    // Word addressed, sampled by the master on ack only
    assign dat_o = mem[adr_i[9:2]];
    // No wait states means ack in the first cycle of the request
    assign ack_o = cyc_i && stb_i && (wait_q == 2'd0);

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wait_q <= 2'd0;
        end else if (ack_o) begin
            // Next read gets 0 to 3 wait states
            wait_q <= 2'($random(seed));
        end else if (cyc_i && stb_i) begin
            wait_q <= wait_q - 2'd1;
        end
    end

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            soft_rstn_i,
    input  logic                            wb_ack_i,
    input  logic [core_pkg::XLEN-1:0]       wb_dat_i,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic [core_pkg::XLEN-1:0]       wb_adr_o,
    output logic                            retire_valid_o,
    output logic [core_pkg::XLEN-1:0]       retire_pc_o,
    output logic [core_pkg::REG_ADDR_W-1:0] retire_rd_o,
    output logic [core_pkg::XLEN-1:0]       retire_data_o
);
    import core_pkg::*;

    // Fetch
    logic                  fetch_valid;
    logic [XLEN-1:0]       fetch_pc;
    logic [XLEN-1:0]       fetch_instr;
    // IF/ID
    logic                  ifid_valid_q;
    logic [XLEN-1:0]       ifid_pc_q;
    logic [XLEN-1:0]       ifid_instr_q;
    // Decode and register read
    dec_instr_t            dec;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    // ID/EX
    logic                  idex_valid_q;
    dec_instr_t            idex_q;
    logic [XLEN-1:0]       rs1_data_q;
    logic [XLEN-1:0]       rs2_data_q;
    dec_instr_t            ex_instr;
    // Execute
    logic [XLEN-1:0]       ex_result;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;
    // EX/WB
    logic                  exwb_valid_q;
    logic                  exwb_we_q;
    logic [XLEN-1:0]       exwb_pc_q;
    logic [REG_ADDR_W-1:0] exwb_rd_q;
    logic [XLEN-1:0]       exwb_data_q;

    fetch_stage fetch_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .soft_rstn_i  (soft_rstn_i),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .wb_ack_i     (wb_ack_i),
        .wb_dat_i     (wb_dat_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_adr_o     (wb_adr_o),
        .fetch_valid_o(fetch_valid),
        .fetch_pc_o   (fetch_pc),
        .fetch_instr_o(fetch_instr)
    );

    // Valid bits: cleared by either reset, IF/ID and ID/EX also by redirect
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            ifid_valid_q <= 1'b0;
            idex_valid_q <= 1'b0;
            exwb_valid_q <= 1'b0;
            exwb_we_q    <= 1'b0;
        end else if (!soft_rstn_i) begin
            ifid_valid_q <= 1'b0;
            idex_valid_q <= 1'b0;
            exwb_valid_q <= 1'b0;
            exwb_we_q    <= 1'b0;
        end else begin
            // Two wrong-path slots squashed
            ifid_valid_q <= fetch_valid && !redirect;
            idex_valid_q <= dec.valid && !redirect;
            // Redirecting instruction itself still retires
            exwb_valid_q <= ex_instr.valid;
            exwb_we_q    <= ex_instr.valid && ex_instr.rf_we;
        end
    end

    // Payload, qualified by the valid bits above
    always_ff @(posedge clk_i) begin
        if (fetch_valid) begin
            ifid_pc_q    <= fetch_pc;
            ifid_instr_q <= fetch_instr;
        end
        idex_q      <= dec;
        rs1_data_q  <= rs1_rdata;
        rs2_data_q  <= rs2_rdata;
        exwb_pc_q   <= ex_instr.pc;
        exwb_rd_q   <= ex_instr.rd;
        exwb_data_q <= ex_result;
    end

    decoder decoder_i (
        .valid_i(ifid_valid_q),
        .pc_i   (ifid_pc_q),
        .instr_i(ifid_instr_q),
        .dec_o  (dec)
    );

    // Read in ID, written from EX/WB
    regfile regfile_i (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .we_i    (exwb_we_q),
        .waddr_i (exwb_rd_q),
        .wdata_i (exwb_data_q),
        .raddr1_i(dec.rs1),
        .raddr2_i(dec.rs2),
        .rdata1_o(rs1_rdata),
        .rdata2_o(rs2_rdata)
    );

    // EX sees the flushable valid bit, not the one stored with the payload
    always_comb begin
        ex_instr       = idex_q;
        ex_instr.valid = idex_valid_q;
    end

    exe_stage exe_i (
        .instr_i      (ex_instr),
        .rs1_data_i   (rs1_data_q),
        .rs2_data_i   (rs2_data_q),
        .wb_valid_i   (exwb_we_q),
        .wb_rd_i      (exwb_rd_q),
        .wb_data_i    (exwb_data_q),
        .result_o     (ex_result),
        .redirect_o   (redirect),
        .redirect_pc_o(redirect_pc)
    );

    // Retire port, one cycle per instruction
    assign retire_valid_o = exwb_valid_q;
    assign retire_pc_o    = exwb_pc_q;
    assign retire_rd_o    = exwb_rd_q;
    assign retire_data_o  = exwb_data_q;

endmodule

/* hw/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage (
    input  core_pkg::dec_instr_t            instr_i,
    input  logic [core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_data_i,
    input  logic                            wb_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [core_pkg::XLEN-1:0]       wb_data_i,
    output logic [core_pkg::XLEN-1:0]       result_o,
    output logic                            redirect_o,
    output logic [core_pkg::XLEN-1:0]       redirect_pc_o
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [4:0]      shamt;
    logic            taken;

    // Bypass from the EX/WB register, x0 never forwarded
    function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] idx,
                                            input logic [XLEN-1:0]       rf_data);
        logic hit;
        hit = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == idx);
        return hit ? wb_data_i : rf_data;
    endfunction

    always_comb begin
        op_a    = fwd(instr_i.rs1, rs1_data_i);
        rs2_val = fwd(instr_i.rs2, rs2_data_i);
    end

    assign op_b    = instr_i.use_imm ? instr_i.imm : rs2_val;
    // Only the low 5 bits count for shifts
    assign shamt   = op_b[4:0];

    always_comb begin
        case (instr_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branches compare the two registers, never the immediate
    always_comb begin
        case (instr_i.br_op)
            BR_EQ:   taken = (op_a == rs2_val);
            BR_NE:   taken = (op_a != rs2_val);
            BR_LT:   taken = ($signed(op_a) < $signed(rs2_val));
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Not-taken prediction, so any taken transfer redirects
    assign redirect_o    = instr_i.valid && taken;
    assign redirect_pc_o = instr_i.pc + instr_i.imm;

    // JAL links pc+4, conditional branches carry zero
    always_comb begin
        case (instr_i.br_op)
            BR_NONE: result_o = alu_res;
            BR_JAL:  result_o = instr_i.pc + XLEN'(4);
            default: result_o = '0;
        endcase
    end

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);
    import core_pkg::*;

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Write in WB visible to the read in ID on the same cycle
    assign rdata1_o = (raddr1_i == '0)                   ? '0      :
                      (we_i && (raddr1_i == waddr_i))    ? wdata_i :
                                                           regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                   ? '0      :
                      (we_i && (raddr2_i == waddr_i))    ? wdata_i :
                                                           regs_q[raddr2_i];

    // Decoder clears rf_we for rd 0, so WB never targets x0
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        we_i |-> (waddr_i != '0));

endmodule

/* hw/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic                      valid_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic [31:0]               instr_i,
    output core_pkg::dec_instr_t      dec_o
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;
    logic       writes_rd;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // Defaults match the I-type layout
        supported     = 1'b1;
        writes_rd     = 1'b1;
        dec_o.pc      = pc_i;
        dec_o.rs1     = instr_i[19:15];
        dec_o.rs2     = instr_i[24:20];
        dec_o.rd      = instr_i[11:7];
        dec_o.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        dec_o.use_imm = 1'b0;
        dec_o.alu_op  = ALU_ADD;
        dec_o.br_op   = BR_NONE;
        case (opcode)
            OPC_OP_IMM: begin
                dec_o.use_imm = 1'b1;
                case (funct3)
                    3'b000:  dec_o.alu_op = ALU_ADD;
                    3'b010:  dec_o.alu_op = ALU_SLT;
                    3'b100:  dec_o.alu_op = ALU_XOR;
                    3'b110:  dec_o.alu_op = ALU_OR;
                    3'b111:  dec_o.alu_op = ALU_AND;
                    // Immediate shifts and SLTIU not in the subset
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: dec_o.alu_op = ALU_SLL;
                    {7'b0000000, 3'b010}: dec_o.alu_op = ALU_SLT;
                    {7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b101}: dec_o.alu_op = ALU_SRL;
                    {7'b0100000, 3'b101}: dec_o.alu_op = ALU_SRA;
                    {7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
                    default:              supported = 1'b0;
                endcase
            end
            OPC_LUI: begin
                // Upper immediate straight through the ALU
                dec_o.imm     = {instr_i[31:12], 12'b0};
                dec_o.use_imm = 1'b1;
                dec_o.alu_op  = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                // No destination, retires as rd 0
                writes_rd = 1'b0;
                dec_o.rd  = '0;
                dec_o.imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                             instr_i[11:8], 1'b0};
                case (funct3)
                    3'b000:  dec_o.br_op = BR_EQ;
                    3'b001:  dec_o.br_op = BR_NE;
                    3'b100:  dec_o.br_op = BR_LT;
                    default: supported = 1'b0;
                endcase
            end
            OPC_JAL: begin
                dec_o.br_op = BR_JAL;
                dec_o.imm   = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                               instr_i[30:21], 1'b0};
            end
            default: supported = 1'b0;
        endcase
        // Unknown encodings become bubbles
        dec_o.valid = valid_i && supported;
        dec_o.rf_we = writes_rd && (dec_o.rd != '0);
    end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      soft_rstn_i,
    input  logic                      redirect_i,
    input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                      wb_ack_i,
    input  logic [core_pkg::XLEN-1:0] wb_dat_i,
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic [core_pkg::XLEN-1:0] wb_adr_o,
    output logic                      fetch_valid_o,
    output logic [core_pkg::XLEN-1:0] fetch_pc_o,
    output logic [core_pkg::XLEN-1:0] fetch_instr_o
);
    import core_pkg::*;

    // Bus cycle in progress
    logic            cyc_q;
    // In-flight read belongs to a squashed path
    logic            discard_q;
    // Next address to fetch
    logic [XLEN-1:0] pc_q;
    // Address of the read on the bus
    logic [XLEN-1:0] adr_q;
    logic            ack_done;
    logic [XLEN-1:0] start_pc;

    assign ack_done = cyc_q && wb_ack_i;
    // A redirect on the start edge wins over the sequential PC
    assign start_pc = redirect_i ? redirect_pc_i : pc_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            cyc_q     <= 1'b0;
            discard_q <= 1'b0;
            pc_q      <= RESET_PC;
        end else if (!soft_rstn_i) begin
            cyc_q     <= 1'b0;
            discard_q <= 1'b0;
            pc_q      <= RESET_PC;
        end else begin
            // One read at a time, idle cycle after each ack
            if (!cyc_q) begin
                cyc_q <= 1'b1;
            end else if (wb_ack_i) begin
                cyc_q <= 1'b0;
            end
            // Redirect mid-read: let the slave finish, then drop the data
            if (ack_done) begin
                discard_q <= 1'b0;
            end else if (cyc_q && redirect_i) begin
                discard_q <= 1'b1;
            end
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (ack_done && !discard_q) begin
                pc_q <= adr_q + XLEN'(4);
            end
        end
    end

    // Address latched when a read starts, held until ack
    always_ff @(posedge clk_i) begin
        if (!cyc_q) begin
            adr_q <= start_pc;
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_adr_o = adr_q;

    // Valid for the ack cycle only; redirect on the same edge is flushed in IF/ID
    assign fetch_valid_o = ack_done && !discard_q;
    assign fetch_pc_o    = adr_q;
    assign fetch_instr_o = wb_dat_i;

    // Classic cycle: request held with a steady address until ack
    a_adr_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wb_stb_o && !wb_ack_i && soft_rstn_i) |=> (wb_stb_o && $stable(wb_adr_o)));

endmodule

/* hw/core_pkg.sv */
package core_pkg;

    // Datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Boot address, used after hard and soft reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_t;

    // Control transfer kinds
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_JAL
    } br_op_t;

    // Decoded instruction, carried from ID into EX
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        // Already sign-extended
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        alu_op_t               alu_op;
        br_op_t                br_op;
        logic                  rf_we;
    } dec_instr_t;

endpackage
